/* files.f */
logic/fe_pkg.sv
logic/fe_imem.sv
logic/fe_pc_gen.sv
logic/fe_control.sv
logic/fe_fetch_stage.sv
logic/fe_top.sv
sim/fe_checker.sv
sim/fe_tb.sv

/* sim/fe_tb.sv */
module fe_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import fe_pkg::*;

  localparam int vaddr_width_lp    = 32;
  localparam int imem_words_lp     = 64;
  localparam int timeout_cycles_lp = 500;

  logic                       clk_i;
  logic                       reset_i;
  fe_opcode_e                 fe_cmd_opcode;
  logic [vaddr_width_lp-1:0]  fe_cmd_vaddr;
  logic [instr_width_gp-1:0]  fe_cmd_instr;
  logic                       fe_cmd_v;
  logic                       fe_cmd_yumi;
  logic                       fe_queue_v;
  logic                       fe_queue_ready;
  fe_msg_type_e               fe_queue_msg_type;
  logic [vaddr_width_lp-1:0]  fe_queue_pc;
  logic [instr_width_gp-1:0]  fe_queue_instr;

  int          msg_count;
  int          exc_count;
  int          error_count;
  int          timeout_count = 0;
  logic        random_ready = 1'b0;
  logic [31:0] lcg_state = 32'hcb18;

  always #20 clk_i = ~clk_i;

  fe_top
   #(.vaddr_width_p(vaddr_width_lp)
     ,.imem_words_p(imem_words_lp)
     )
   u_dut
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.fe_cmd_opcode_i(fe_cmd_opcode)
     ,.fe_cmd_vaddr_i(fe_cmd_vaddr)
     ,.fe_cmd_instr_i(fe_cmd_instr)
     ,.fe_cmd_v_i(fe_cmd_v)
     ,.fe_cmd_yumi_o(fe_cmd_yumi)
     ,.fe_queue_v_o(fe_queue_v)
     ,.fe_queue_ready_i(fe_queue_ready)
     ,.fe_queue_msg_type_o(fe_queue_msg_type)
     ,.fe_queue_pc_o(fe_queue_pc)
     ,.fe_queue_instr_o(fe_queue_instr)
     );

  fe_checker
   #(.vaddr_width_p(vaddr_width_lp)
     ,.imem_words_p(imem_words_lp)
     )
   u_checker
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.cmd_opcode_i(fe_cmd_opcode)
     ,.cmd_vaddr_i(fe_cmd_vaddr)
     ,.cmd_instr_i(fe_cmd_instr)
     ,.cmd_v_i(fe_cmd_v)
     ,.cmd_yumi_i(fe_cmd_yumi)
     ,.queue_v_i(fe_queue_v)
     ,.queue_ready_i(fe_queue_ready)
     ,.queue_msg_type_i(fe_queue_msg_type)
     ,.queue_pc_i(fe_queue_pc)
     ,.queue_instr_i(fe_queue_instr)
     ,.msg_count_o(msg_count)
     ,.exc_count_o(exc_count)
     ,.error_count_o(error_count)
     );

  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Inputs change only right after a falling edge
  task automatic next_cycle();
    @(negedge clk_i);
    if (random_ready)
    begin
      lcg_state      = lcg_step(lcg_state);
      fe_queue_ready = lcg_state[16];
    end
  endtask

  task automatic send_command(input fe_opcode_e opcode, input logic [31:0] vaddr,
                              input logic [31:0] instr);
    fe_cmd_opcode = opcode;
    fe_cmd_vaddr  = vaddr;
    fe_cmd_instr  = instr;
    fe_cmd_v      = 1'b1;
    next_cycle();
    fe_cmd_v      = 1'b0;
  endtask

  task automatic wait_for_count(input bit exceptions, input int target);
    int cycles;
    cycles = 0;
    while (((exceptions ? exc_count : msg_count) < target) && (cycles < timeout_cycles_lp))
    begin
      next_cycle();
      cycles++;
    end
    if ((exceptions ? exc_count : msg_count) < target)
    begin
      timeout_count++;
      $display("Error at %0t ns: timed out waiting for %0d %s", $time, target,
               exceptions ? "exception messages" : "queue messages");
    end
  endtask

  initial
  begin
    clk_i          = 1'b0;
    reset_i        = 1'b1;
    fe_cmd_opcode  = e_op_wait;
    fe_cmd_vaddr   = '0;
    fe_cmd_instr   = '0;
    fe_cmd_v       = 1'b0;
    fe_queue_ready = 1'b1;
    repeat (3) next_cycle();
    reset_i = 1'b0;

    // Load every word while idle
    for (int i = 0; i < imem_words_lp; i++)
    begin
      lcg_state = lcg_step(lcg_state);
      send_command(e_op_imem_fill, i * 4, lcg_state);
    end
    repeat (4) next_cycle();

    // Straight-line fetch, then the same run under random back-pressure
    for (int pass = 0; pass < 2; pass++)
    begin
      random_ready = (pass == 1);
      send_command(e_op_pc_redirect, 32'h40, '0);
      wait_for_count(1'b0, msg_count + 10);
      send_command(e_op_wait, '0, '0);
      random_ready = 1'b0;
      fe_queue_ready = 1'b1;
      repeat (6) next_cycle();
    end

    // Misaligned target, then running off the end of memory
    send_command(e_op_pc_redirect, 32'h46, '0);
    wait_for_count(1'b1, exc_count + 1);
    repeat (6) next_cycle();
    send_command(e_op_pc_redirect, 32'he0, '0);
    wait_for_count(1'b1, exc_count + 1);
    repeat (6) next_cycle();

    // Fill while running, once with ready held high and once with it toggling
    send_command(e_op_pc_redirect, 32'h00, '0);
    wait_for_count(1'b0, msg_count + 4);
    lcg_state = lcg_step(lcg_state);
    send_command(e_op_imem_fill, 32'h20, lcg_state);
    wait_for_count(1'b0, msg_count + 12);
    send_command(e_op_wait, '0, '0);
    repeat (4) next_cycle();
    random_ready = 1'b1;
    send_command(e_op_pc_redirect, 32'h1c, '0);
    wait_for_count(1'b0, msg_count + 3);
    lcg_state = lcg_step(lcg_state);
    send_command(e_op_imem_fill, 32'h34, lcg_state);
    wait_for_count(1'b0, msg_count + 8);
    send_command(e_op_wait, '0, '0);
    random_ready = 1'b0;
    fe_queue_ready = 1'b1;
    repeat (6) next_cycle();

    $display("Run complete: %0d messages, %0d exceptions, %0d errors, %0d timeouts",
             msg_count, exc_count, error_count, timeout_count);
    if ((error_count == 0) && (timeout_count == 0))
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

/* sim/fe_checker.sv */
module fe_checker
  #(parameter int vaddr_width_p = 32
    , parameter int imem_words_p = 64
    )
  (input                                 clk_i
   , input                               reset_i

   , input fe_pkg::fe_opcode_e           cmd_opcode_i
   , input [vaddr_width_p-1:0]           cmd_vaddr_i
   , input [fe_pkg::instr_width_gp-1:0]  cmd_instr_i
   , input                               cmd_v_i
   , input                               cmd_yumi_i

   , input                               queue_v_i
   , input                               queue_ready_i
   , input fe_pkg::fe_msg_type_e         queue_msg_type_i
   , input [vaddr_width_p-1:0]           queue_pc_i
   , input [fe_pkg::instr_width_gp-1:0]  queue_instr_i

   , output int                          msg_count_o
   , output int                          exc_count_o
   , output int                          error_count_o
   );

  timeunit 1ns;
  timeprecision 1ps;

  import fe_pkg::*;

  localparam int idx_width_lp = $clog2(imem_words_p);

  logic [instr_width_gp-1:0] mem_model [imem_words_p];
  logic [vaddr_width_p-1:0]  exp_pc = '0;
  logic                      expect_msgs = 1'b0;
  int                        redirect_age = 0;
  int                        msg_count = 0;
  int                        exc_count = 0;
  int                        error_count = 0;

  assign msg_count_o   = msg_count;
  assign exc_count_o   = exc_count;
  assign error_count_o = error_count;

  task automatic report_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
    error_count++;
    $display("FAILED at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
  endtask

  task automatic report_problem(input string text);
    error_count++;
    $display("Error at %0t ns: %s", $time, text);
  endtask

  task automatic check_message();
    logic fault;
    fault = (exp_pc[1:0] != 2'b00) || (exp_pc >= imem_words_p * 4);
    msg_count++;
    assert (expect_msgs)
    else report_problem("a message left the front end while no fetch was expected");
    assert (redirect_age >= 2)
    else report_problem("a message came sooner than two cycles after a redirect");
    assert (queue_pc_i == exp_pc)
    else report_mismatch("fe_queue_pc_o", exp_pc, queue_pc_i);
    if (fault)
    begin
      exc_count++;
      assert (queue_msg_type_i == e_fe_exception)
      else report_mismatch("fe_queue_msg_type_o", e_fe_exception, queue_msg_type_i);
      // Front end goes quiet until the next redirect
      expect_msgs = 1'b0;
    end
    else
    begin
      assert (queue_msg_type_i == e_fe_fetch)
      else report_mismatch("fe_queue_msg_type_o", e_fe_fetch, queue_msg_type_i);
      assert (queue_instr_i == mem_model[exp_pc[idx_width_lp+1:2]])
      else report_mismatch("fe_queue_instr_o", mem_model[exp_pc[idx_width_lp+1:2]],
                           queue_instr_i);
    end
    exp_pc = exp_pc + 4;
  endtask

  task automatic track_command();
    case (cmd_opcode_i)
      e_op_pc_redirect:
      begin
        exp_pc       = cmd_vaddr_i;
        expect_msgs  = 1'b1;
        redirect_age = 0;
      end
      e_op_imem_fill:
        mem_model[cmd_vaddr_i[idx_width_lp+1:2]] = cmd_instr_i;
      e_op_wait:
        expect_msgs = 1'b0;
    endcase
  endtask

  always @(posedge clk_i)
  begin
    assert (cmd_yumi_i === cmd_v_i)
    else report_mismatch("fe_cmd_yumi_o", cmd_v_i, cmd_yumi_i);
    if (reset_i)
    begin
      expect_msgs  = 1'b0;
      redirect_age = 0;
    end
    else
    begin
      redirect_age++;
      assert (!$isunknown(queue_v_i))
      else report_problem("fe_queue_v_o is unknown after reset");
      assert (!(queue_v_i && !queue_ready_i))
      else report_problem("fe_queue_v_o was high while fe_queue_ready_i was low");
      if (queue_v_i === 1'b1)
        check_message();
      if (cmd_v_i && cmd_yumi_i)
        track_command();
    end
  end

endmodule

/* logic/fe_top.sv */
module fe_top
  #(parameter int vaddr_width_p = 32
    , parameter int imem_words_p = 64
    )
  (input                                   clk_i
   , input                                 reset_i

   , input fe_pkg::fe_opcode_e             fe_cmd_opcode_i
   , input [vaddr_width_p-1:0]             fe_cmd_vaddr_i
   , input [fe_pkg::instr_width_gp-1:0]    fe_cmd_instr_i
   , input                                 fe_cmd_v_i
   , output logic                          fe_cmd_yumi_o

   , output logic                          fe_queue_v_o
   , input                                 fe_queue_ready_i
   , output fe_pkg::fe_msg_type_e          fe_queue_msg_type_o
   , output logic [vaddr_width_p-1:0]      fe_queue_pc_o
   , output logic [fe_pkg::instr_width_gp-1:0] fe_queue_instr_o
   );

  import fe_pkg::*;

  // Word index bits of a byte address
  localparam int imem_idx_width_lp = $clog2(imem_words_p);

  logic                      redirect_v;
  logic [vaddr_width_p-1:0]  redirect_pc;
  logic                      fetch_v;
  logic                      fill_v;
  logic                      cmd_flush;
  logic [vaddr_width_p-1:0]  next_pc;
  logic [vaddr_width_p-1:0]  if2_pc;
  logic [instr_width_gp-1:0] rdata;
  logic                      fetch_fail;
  logic                      exception_sent;
  logic                      send_blocked;

  fe_control
   #(.vaddr_width_p(vaddr_width_p))
   u_control
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.cmd_opcode_i(fe_cmd_opcode_i)
     ,.cmd_vaddr_i(fe_cmd_vaddr_i)
     ,.cmd_v_i(fe_cmd_v_i)
     ,.if2_pc_i(if2_pc)
     ,.fetch_fail_i(fetch_fail)
     ,.exception_sent_i(exception_sent)
     ,.send_blocked_i(send_blocked)
     ,.cmd_yumi_o(fe_cmd_yumi_o)
     ,.redirect_v_o(redirect_v)
     ,.redirect_pc_o(redirect_pc)
     ,.fetch_v_o(fetch_v)
     ,.fill_v_o(fill_v)
     ,.cmd_flush_o(cmd_flush)
     );

  fe_pc_gen
   #(.vaddr_width_p(vaddr_width_p))
   u_pc_gen
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.redirect_v_i(redirect_v)
     ,.redirect_pc_i(redirect_pc)
     ,.fetch_v_i(fetch_v)
     ,.next_pc_o(next_pc)
     ,.if2_pc_o(if2_pc)
     );

  fe_imem
   #(.imem_words_p(imem_words_p))
   u_imem
    (.clk_i(clk_i)
     ,.fill_v_i(fill_v)
     ,.fill_addr_i(fe_cmd_vaddr_i[imem_idx_width_lp+1:2])
     ,.fill_data_i(fe_cmd_instr_i)
     ,.read_v_i(fetch_v)
     ,.read_addr_i(next_pc[imem_idx_width_lp+1:2])
     ,.rdata_o(rdata)
     );

  fe_fetch_stage
   #(.vaddr_width_p(vaddr_width_p)
     ,.imem_words_p(imem_words_p)
     )
   u_fetch_stage
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.fetch_v_i(fetch_v)
     ,.cmd_flush_i(cmd_flush)
     ,.if2_pc_i(if2_pc)
     ,.rdata_i(rdata)
     ,.queue_ready_i(fe_queue_ready_i)
     ,.queue_v_o(fe_queue_v_o)
     ,.queue_msg_type_o(fe_queue_msg_type_o)
     ,.queue_pc_o(fe_queue_pc_o)
     ,.queue_instr_o(fe_queue_instr_o)
     ,.fetch_fail_o(fetch_fail)
     ,.exception_sent_o(exception_sent)
     ,.send_blocked_o(send_blocked)
     );

endmodule

/* logic/fe_fetch_stage.sv */
module fe_fetch_stage
  #(parameter int vaddr_width_p = 32
    , parameter int imem_words_p = 64
    )
  (input                                       clk_i
   , input                                     reset_i

   , input                                     fetch_v_i
   , input                                     cmd_flush_i
   , input [vaddr_width_p-1:0]                 if2_pc_i
   , input [fe_pkg::instr_width_gp-1:0]        rdata_i

   , input                                     queue_ready_i
   , output logic                              queue_v_o
   , output fe_pkg::fe_msg_type_e              queue_msg_type_o
   , output logic [vaddr_width_p-1:0]          queue_pc_o
   , output logic [fe_pkg::instr_width_gp-1:0] queue_instr_o

   , output logic                              fetch_fail_o
   , output logic                              exception_sent_o
   , output logic                              send_blocked_o
   );

  import fe_pkg::*;

  // Byte address bits covered by the memory
  localparam int byte_addr_width_lp = $clog2(imem_words_p) + 2;

  logic v_if1_r;
  logic v_if2_r;
  logic blocked_r;
  logic kill;
  logic misaligned;
  logic out_of_range;
  logic fault;
  logic [instr_width_gp-1:0] instr_if2_r;

  assign misaligned   = |if2_pc_i[1:0];
  assign out_of_range = |if2_pc_i[vaddr_width_p-1:byte_addr_width_lp];
  assign fault        = misaligned | out_of_range;

  // Ready must already be high when a message is offered
  assign queue_v_o        = v_if2_r & queue_ready_i & ~cmd_flush_i;
  assign fetch_fail_o     = v_if2_r & ~queue_v_o;
  assign exception_sent_o = queue_v_o & fault;
  assign kill             = cmd_flush_i | fetch_fail_o | exception_sent_o;

  // A failed fetch stays pending until the queue has room again
  assign send_blocked_o = (v_if2_r | blocked_r) & ~queue_ready_i;

  assign queue_msg_type_o = fault ? e_fe_exception : e_fe_fetch;
  assign queue_pc_o       = if2_pc_i;
  assign queue_instr_o    = fault ? '0 : instr_if2_r;

  always_ff @(posedge clk_i)
  begin
    if (v_if1_r)
      instr_if2_r <= rdata_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      v_if1_r   <= 1'b0;
      v_if2_r   <= 1'b0;
      blocked_r <= 1'b0;
    end
    else
    begin
      v_if1_r   <= fetch_v_i;
      v_if2_r   <= v_if1_r & ~kill;
      blocked_r <= send_blocked_o & ~cmd_flush_i;
    end
  end

endmodule

/* logic/fe_control.sv */
module fe_control
  #(parameter int vaddr_width_p = 32)
  (input                               clk_i
   , input                             reset_i

   , input fe_pkg::fe_opcode_e         cmd_opcode_i
   , input [vaddr_width_p-1:0]         cmd_vaddr_i
   , input                             cmd_v_i
   , output logic                      cmd_yumi_o

   , input [vaddr_width_p-1:0]         if2_pc_i
   , input                             fetch_fail_i
   , input                             exception_sent_i
   , input                             send_blocked_i

   , output logic                      redirect_v_o
   , output logic [vaddr_width_p-1:0]  redirect_pc_o
   , output logic                      fetch_v_o
   , output logic                      fill_v_o
   , output logic                      cmd_flush_o
   );

  import fe_pkg::*;

  fe_state_e state_r, state_n;

  logic redirect_cmd;
  logic fill_cmd;
  logic wait_cmd;
  logic is_run;
  logic is_stall;
  logic unstall;
  logic redirect_r;
  logic [vaddr_width_p-1:0] pc_resume_r;

  assign redirect_cmd = cmd_v_i & (cmd_opcode_i == e_op_pc_redirect);
  assign fill_cmd     = cmd_v_i & (cmd_opcode_i == e_op_imem_fill);
  assign wait_cmd     = cmd_v_i & (cmd_opcode_i == e_op_wait);

  assign is_run   = (state_r == e_run);
  assign is_stall = (state_r == e_stall);

  // Every command is taken in its own cycle and drops the fetches in flight
  assign cmd_yumi_o  = cmd_v_i;
  assign cmd_flush_o = cmd_v_i;
  assign fill_v_o    = fill_cmd;

  assign unstall = ~send_blocked_i & ~cmd_v_i;

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      e_wait:
        state_n = redirect_cmd ? e_run : e_wait;
      e_run:
      begin
        if (redirect_cmd)
          state_n = e_run;
        else if (wait_cmd)
          state_n = e_wait;
        else if (fill_cmd | fetch_fail_i)
          state_n = e_stall;
        else if (exception_sent_i)
          state_n = e_wait;
      end
      e_stall:
      begin
        if (redirect_cmd)
          state_n = e_run;
        else if (wait_cmd)
          state_n = e_wait;
        else if (unstall)
          state_n = e_run;
      end
      default:
        state_n = e_wait;
    endcase
  end

  assign fetch_v_o     = (state_n == e_run);
  assign redirect_v_o  = redirect_cmd | (is_stall & fetch_v_o);
  assign redirect_pc_o = redirect_cmd ? cmd_vaddr_i : pc_resume_r;

  // IF2 holds a stale PC in the first run cycle after a redirect
  always_ff @(posedge clk_i)
  begin
    if (redirect_cmd)
      pc_resume_r <= cmd_vaddr_i;
    else if (is_run & ~redirect_r)
      pc_resume_r <= if2_pc_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r    <= e_wait;
      redirect_r <= 1'b0;
    end
    else
    begin
      state_r    <= state_n;
      redirect_r <= redirect_v_o;
    end
  end

  a_fill_not_redirect: assert property (@(posedge clk_i) disable iff (reset_i)
    !(fill_v_o && redirect_v_o))
    else $error("memory fill and redirect in the same cycle");

endmodule

/* logic/fe_pc_gen.sv */
module fe_pc_gen
  #(parameter int vaddr_width_p = 32)
  (input                               clk_i
   , input                             reset_i

   , input                             redirect_v_i
   , input [vaddr_width_p-1:0]         redirect_pc_i
   , input                             fetch_v_i

   , output logic [vaddr_width_p-1:0]  next_pc_o
   , output logic [vaddr_width_p-1:0]  if2_pc_o
   );

  // PC of the instruction now in IF1
  logic [vaddr_width_p-1:0] pc_r;
  logic [vaddr_width_p-1:0] pc_if2_r;

  always_comb
  begin
    if (redirect_v_i)
      next_pc_o = redirect_pc_i;
    else
      next_pc_o = pc_r + vaddr_width_p'(4);
  end

  // Pipeline only moves when a new fetch is issued
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      pc_r     <= '0;
      pc_if2_r <= '0;
    end
    else if (fetch_v_i)
    begin
      pc_r     <= next_pc_o;
      pc_if2_r <= pc_r;
    end
  end

  assign if2_pc_o = pc_if2_r;

endmodule

/* logic/fe_imem.sv */
module fe_imem
  #(parameter int imem_words_p = 64
    , localparam int idx_width_lp = $clog2(imem_words_p)
    )
  (input                                       clk_i

   , input                                     fill_v_i
   , input [idx_width_lp-1:0]                  fill_addr_i
   , input [fe_pkg::instr_width_gp-1:0]        fill_data_i

   , input                                     read_v_i
   , input [idx_width_lp-1:0]                  read_addr_i
   , output logic [fe_pkg::instr_width_gp-1:0] rdata_o
   );

  import fe_pkg::*;

  logic [instr_width_gp-1:0] mem [imem_words_p];

  // Read returns the old word on a same-cycle write
  always_ff @(posedge clk_i)
  begin
    if (fill_v_i)
      mem[fill_addr_i] <= fill_data_i;
    if (read_v_i)
      rdata_o <= mem[read_addr_i];
  end

  // Code is loaded into every word before the first fetch
  a_rdata_known: assert property (@(posedge clk_i)
    read_v_i |=> !$isunknown(rdata_o))
    else $error("instruction memory returned unknown data");

endmodule

/* logic/fe_pkg.sv */
package fe_pkg;

  // Instructions are fixed at 4 bytes
  localparam int instr_width_gp = 32;

  // Commands from the back end
  typedef enum logic [1:0]
  {
    e_op_pc_redirect = 2'd0
    , e_op_imem_fill = 2'd1
    , e_op_wait      = 2'd2
  } fe_opcode_e;

  // Front end control states
  typedef enum logic [1:0]
  {
    e_wait    = 2'd0
    , e_run   = 2'd1
    , e_stall = 2'd2
  } fe_state_e;

  // Message kinds on the fetch queue
  typedef enum logic
  {
    e_fe_fetch       = 1'b0
    , e_fe_exception = 1'b1
  } fe_msg_type_e;

endpackage
